// File: Bender.yml
package:
  name: imsic

sources:
  - verilog/imsic_pkg.sv
  - verilog/imsic_csr_if.sv
  - verilog/imsic_state_if.sv
  - verilog/imsic_csr_decode.sv
  - verilog/imsic_file_regs.sv
  - verilog/imsic_topei.sv
  - verilog/imsic_top.sv
  - target: test
    files:
      - test/tb_imsic.sv

// File: filelist.f
verilog/imsic_pkg.sv
verilog/imsic_csr_if.sv
verilog/imsic_state_if.sv
verilog/imsic_csr_decode.sv
verilog/imsic_file_regs.sv
verilog/imsic_topei.sv
verilog/imsic_top.sv
test/tb_imsic.sv

// File: test/imsic_golden.txt
# op addr file priv v vgein data | illegal rdata irq topei_m topei_s topei_vs
# op: 0 write, 1 read, 2 setipnum (file, id in data), 3 check; all fields hex
1 070 0 0 0 0 0 0 0 0 0 0 0
1 080 0 0 0 0 0 0 0 0 0 0 0
1 0C0 1 0 0 0 0 0 0 0 0 0 0
0 0C0 0 0 0 0 F6 0 0 0 0 0 0
1 0C0 0 0 0 0 0 0 F6 0 0 0 0
0 072 0 0 0 0 6 0 0 0 0 0 0
1 072 0 0 0 0 0 0 6 0 0 0 0
0 070 0 0 0 0 FF 0 0 0 0 0 0
1 070 0 0 0 0 0 0 1 0 0 0 0
0 080 0 0 0 0 35 0 0 1 2 0 0
1 080 0 0 0 0 0 0 34 1 2 0 0
0 072 0 0 0 0 2 0 0 0 0 0 0
0 072 0 0 0 0 0 0 0 1 2 0 0
0 0C0 1 0 0 0 FFFFFFFFFFFFFFFF 0 0 1 2 0 0
0 080 1 0 0 0 100 0 0 1 2 8 0
2 000 1 0 0 0 3 0 0 1 2 3 0
1 080 1 0 0 0 0 0 108 1 2 3 0
2 000 1 0 0 0 0 0 0 1 2 3 0
1 080 1 0 0 0 0 0 108 1 2 3 0
0 0C0 0 1 0 0 0 1 0 1 2 3 0
1 081 0 0 0 0 0 1 0 1 2 3 0
0 082 0 0 0 0 FF 1 0 1 2 3 0
1 030 0 0 1 0 0 1 0 1 2 3 0
0 010 0 0 0 0 0 1 0 1 2 3 0
1 0C0 0 0 0 0 0 0 F6 1 2 3 0
0 030 0 0 0 0 FF 0 0 1 2 3 0
0 070 2 0 0 0 1 0 0 1 2 3 0
0 0C0 2 0 0 0 FFFFFFFFFFFFFFFF 0 0 1 2 3 0
2 000 2 0 0 0 5 0 0 5 2 3 5
0 0C0 3 0 0 0 FFFFFFFFFFFFFFFF 0 0 5 2 3 5
0 080 3 0 0 0 200 0 0 5 2 3 5
3 000 0 0 0 1 0 0 0 1 2 3 9

// File: test/tb_imsic.sv
// ==========================================================================
// tb_imsic
// Replays the golden operation list on the IMSIC block and checks read
// data, the illegal flag, the interrupt lines and the top identities.
// ==========================================================================
`default_nettype none

module tb_imsic import imsic_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic               clk;
    logic               rstn;
    logic [11:0]        i_csr_addr;
    logic               i_csr_wdata_vld;
    logic               i_csr_rd;
    xlen_t              i_csr_wdata;
    logic [FILE_W-1:0]  i_file_sel;
    logic               i_priv_illegal;
    logic               i_csr_v;
    logic [VGEIN_W-1:0] i_vgein;
    logic               i_setipnum_vld;
    logic [FILE_W-1:0]  i_setipnum_file;
    logic [ID_W-1:0]    i_setipnum;
    xlen_t              o_csr_rdata;
    logic               o_csr_rdata_vld;
    logic               o_csr_illegal;
    logic [2:0]         o_irq;
    logic [TOPEI_W-1:0] o_topei_m;
    logic [TOPEI_W-1:0] o_topei_s;
    logic [TOPEI_W-1:0] o_topei_vs;

    // fields of the current golden line.
    logic [3:0]  f_op;          // 0 write, 1 read, 2 setipnum, 3 check.
    logic [11:0] f_addr;
    logic [1:0]  f_file;
    logic        f_priv;
    logic        f_v;
    logic        f_vgein;
    logic [63:0] f_data;
    logic        e_ill;
    logic [63:0] e_rdata;
    logic [2:0]  e_irq;
    logic [10:0] e_tm;
    logic [10:0] e_ts;
    logic [10:0] e_tvs;

    imsic_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_eq(input logic [63:0] act, input logic [63:0] exp, input string what);
        if (act !== exp) begin
            $display("FAIL @%0t ns: %s is %0h, expected %0h", $time, what, act, exp);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch on %s", what);
        end
    endtask

    // one strobe, then sample the outputs one cycle later.
    task automatic run_op(input int line_no);
        int waited;
        @(posedge clk);
        #2;
        // strobe-free cycle, so both one-cycle flags must be low again.
        check_eq(o_csr_illegal, 1'b0, $sformatf("before line %0d illegal", line_no));
        check_eq(o_csr_rdata_vld, 1'b0, $sformatf("before line %0d rdata_vld", line_no));
        i_csr_addr      = f_addr;
        i_csr_wdata     = f_data;
        i_file_sel      = f_file;
        i_priv_illegal  = f_priv;
        i_csr_v         = f_v;
        i_vgein         = f_vgein;
        i_setipnum_file = f_file;
        i_setipnum      = f_data[ID_W-1:0];
        i_csr_wdata_vld = (f_op == 4'd0);
        i_csr_rd        = (f_op == 4'd1);
        i_setipnum_vld  = (f_op == 4'd2);
        @(posedge clk);
        #2;
        i_csr_wdata_vld = 1'b0;
        i_csr_rd        = 1'b0;
        i_setipnum_vld  = 1'b0;
        check_eq(o_csr_illegal, e_ill, $sformatf("line %0d illegal", line_no));
        check_eq(o_irq, e_irq, $sformatf("line %0d irq", line_no));
        check_eq(o_topei_m, e_tm, $sformatf("line %0d topei_m", line_no));
        check_eq(o_topei_s, e_ts, $sformatf("line %0d topei_s", line_no));
        check_eq(o_topei_vs, e_tvs, $sformatf("line %0d topei_vs", line_no));
        if (f_op == 4'd1 && !e_ill) begin
            waited = 0;
            while (!o_csr_rdata_vld && waited < 10) begin
                @(posedge clk);
                #2;
                waited++;
            end
            if (!o_csr_rdata_vld) begin
                $display("read data never arrived for golden line %0d", line_no);
                $display("STATUS: FAIL");
                $fatal(1, "read timeout");
            end
            check_eq(o_csr_rdata, e_rdata, $sformatf("line %0d rdata", line_no));
        end else begin
            check_eq(o_csr_rdata_vld, 1'b0, $sformatf("line %0d rdata_vld", line_no));
        end
    endtask

    initial begin
        int fd;
        int n;
        int line_no;
        logic [8*256-1:0] text;
        rstn = 1'b0;
        {i_csr_addr, i_csr_wdata_vld, i_csr_rd, i_csr_wdata} = '0;
        {i_file_sel, i_priv_illegal, i_csr_v, i_vgein} = '0;
        {i_setipnum_vld, i_setipnum_file, i_setipnum} = '0;
        repeat (2) @(posedge clk);
        #2;
        rstn = 1'b1;
        fd = $fopen("test/imsic_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file test/imsic_golden.txt");
            $display("STATUS: FAIL");
            $fatal(1, "no stimulus file");
        end
        line_no = 0;
        while (!$feof(fd)) begin
            text = '0;
            n = $fgets(text, fd);
            line_no++;
            n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h", f_op, f_addr,
                        f_file, f_priv, f_v, f_vgein, f_data, e_ill, e_rdata, e_irq,
                        e_tm, e_ts, e_tvs);
            if (n == 13) begin
                run_op(line_no);    // comment and blank lines skipped.
            end
        end
        $fclose(fd);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/imsic_csr_decode.sv
// ==========================================================================
// imsic_csr_decode
// Classifies each CSR strobe into a register access pulse or an illegal
// access; the illegal flag is registered for one cycle.
// ==========================================================================
`default_nettype none

module imsic_csr_decode import imsic_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire logic [11:0]       i_csr_addr,
    input  wire logic              i_csr_wdata_vld,
    input  wire logic              i_csr_rd,
    input  wire xlen_t             i_csr_wdata,
    input  wire logic [FILE_W-1:0] i_file_sel,
    input  wire logic              i_priv_illegal,
    input  wire logic              i_csr_v,
    output      logic              o_csr_illegal,
    imsic_csr_if.dec               csr
);

    reg_kind_e kind;
    logic      reg_hit;    // one of the four implemented registers.
    logic      is_iprio;
    logic      iprio_ok;
    logic      strobe;
    logic      legal;

    // only index 0 of eip/eie exists; any other eip/eie offset, odd or
    // even, falls to the default and is illegal.
    always_comb begin
        kind    = KIND_DELIVERY;
        reg_hit = 1'b1;
        case (i_csr_addr)
            ADDR_EIDELIVERY:  kind = KIND_DELIVERY;
            ADDR_EITHRESHOLD: kind = KIND_THRESHOLD;
            ADDR_EIP0:        kind = KIND_EIP;
            ADDR_EIE0:        kind = KIND_EIE;
            default:          reg_hit = 1'b0;
        endcase
    end

    assign is_iprio = (i_csr_addr >= ADDR_IPRIO_LO) && (i_csr_addr <= ADDR_IPRIO_HI);
    // iprio is not implemented; a legal access does nothing.
    assign iprio_ok = is_iprio && !i_csr_addr[0] && !i_csr_v;

    assign strobe = i_csr_wdata_vld || i_csr_rd;
    assign legal  = !i_priv_illegal && (reg_hit || iprio_ok);

    assign csr.acc_wr    = i_csr_wdata_vld && !i_priv_illegal && reg_hit;
    assign csr.acc_rd    = i_csr_rd && !i_priv_illegal && reg_hit;
    assign csr.acc_file  = i_file_sel;
    assign csr.acc_kind  = kind;
    assign csr.acc_wdata = i_csr_wdata;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_csr_illegal <= 1'b0;
        end else begin
            o_csr_illegal <= strobe && !legal;  // one cycle per bad strobe.
        end
    end

    // the hart issues at most one access per cycle.
    a_one_strobe: assert property (@(posedge clk) disable iff (!rstn)
        !(i_csr_wdata_vld && i_csr_rd));

endmodule

`default_nettype wire

// File: verilog/imsic_csr_if.sv
// ==========================================================================
// imsic_csr_if
// Decoded register accesses from the CSR decoder to the register bank.
// ==========================================================================
`default_nettype none

interface imsic_csr_if import imsic_pkg::*; ();

    logic              acc_wr;     // legal write, one cycle.
    logic              acc_rd;     // legal read, one cycle.
    logic [FILE_W-1:0] acc_file;
    reg_kind_e         acc_kind;
    xlen_t             acc_wdata;

    modport dec (
        output acc_wr, acc_rd, acc_file, acc_kind, acc_wdata
    );

    modport regs (
        input acc_wr, acc_rd, acc_file, acc_kind, acc_wdata
    );

endinterface

`default_nettype wire

// File: verilog/imsic_file_regs.sv
// ==========================================================================
// imsic_file_regs
// Delivery, threshold, pending and enable registers of the four interrupt
// files, with CSR read-back and setipnum pending updates.
// ==========================================================================
`default_nettype none

module imsic_file_regs import imsic_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rstn,
    imsic_csr_if.regs              csr,
    input  wire logic              i_setipnum_vld,
    input  wire logic [FILE_W-1:0] i_setipnum_file,
    input  wire logic [ID_W-1:0]   i_setipnum,
    output      xlen_t             o_csr_rdata,
    output      logic              o_csr_rdata_vld,
    imsic_state_if.regs            st
);

    logic [NR_FILES-1:0] delivery;
    xlen_t               threshold [NR_FILES];
    xlen_t               eip       [NR_FILES];
    xlen_t               eie       [NR_FILES];
    xlen_t               eip_nxt   [NR_FILES];
    xlen_t               rd_data;

    // csr write first, then the incoming msi on top of it.
    always_comb begin
        for (int f = 0; f < NR_FILES; f++) begin
            eip_nxt[f] = eip[f];
        end
        if (csr.acc_wr && csr.acc_kind == KIND_EIP) begin
            eip_nxt[csr.acc_file] = {csr.acc_wdata[XLEN-1:1], 1'b0};  // id 0 never pends.
        end
        if (i_setipnum_vld && i_setipnum != '0) begin
            eip_nxt[i_setipnum_file][i_setipnum] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            delivery <= '0;
            for (int f = 0; f < NR_FILES; f++) begin
                threshold[f] <= '0;
                eip[f]       <= '0;
                eie[f]       <= '0;
            end
        end else begin
            eip <= eip_nxt;
            if (csr.acc_wr) begin
                case (csr.acc_kind)
                    KIND_DELIVERY:  delivery[csr.acc_file]  <= csr.acc_wdata[0];
                    KIND_THRESHOLD: threshold[csr.acc_file] <= csr.acc_wdata;
                    KIND_EIE:       eie[csr.acc_file]       <= csr.acc_wdata;
                    default:        ;                       // eip handled above.
                endcase
            end
        end
    end

    always_comb begin
        case (csr.acc_kind)
            KIND_DELIVERY:  rd_data = xlen_t'(delivery[csr.acc_file]);
            KIND_THRESHOLD: rd_data = threshold[csr.acc_file];
            KIND_EIP:       rd_data = eip[csr.acc_file];
            default:        rd_data = eie[csr.acc_file];
        endcase
    end

    // read data lands one cycle after the strobe and then holds.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_csr_rdata     <= '0;
            o_csr_rdata_vld <= 1'b0;
        end else begin
            o_csr_rdata_vld <= csr.acc_rd;
            if (csr.acc_rd) begin
                o_csr_rdata <= rd_data;
            end
        end
    end

    assign st.delivery  = delivery;
    assign st.threshold = threshold;
    assign st.eip       = eip;
    assign st.eie       = eie;

    // neither the csr path nor setipnum may ever make identity 0 pending.
    for (genvar f = 0; f < NR_FILES; f++) begin : g_eip_chk
        a_no_id0: assert property (@(posedge clk) disable iff (!rstn) !eip[f][0]);
    end

endmodule

`default_nettype wire

// File: verilog/imsic_pkg.sv
// ==========================================================================
// imsic_pkg
// Shared sizes, CSR offsets and types of the IMSIC interrupt-file block.
// ==========================================================================
`default_nettype none

package imsic_pkg;

    localparam int XLEN     = 64;
    localparam int NR_FILES = 4;        // m, s, guest 0, guest 1.
    localparam int FILE_W   = 2;
    localparam int ID_W     = 6;        // 64 identities per file.
    localparam int TOPEI_W  = 11;       // width of the spec's identity field.
    localparam int VGEIN_W  = 1;        // guest file = 2 + vgein.

    // indirect CSR offsets of an interrupt file.
    localparam logic [11:0] ADDR_IPRIO_LO    = 12'h030;
    localparam logic [11:0] ADDR_IPRIO_HI    = 12'h03F;
    localparam logic [11:0] ADDR_EIDELIVERY  = 12'h070;
    localparam logic [11:0] ADDR_EITHRESHOLD = 12'h072;
    localparam logic [11:0] ADDR_EIP0        = 12'h080;
    localparam logic [11:0] ADDR_EIE0        = 12'h0C0;

    typedef enum logic [1:0] {
        KIND_DELIVERY,
        KIND_THRESHOLD,
        KIND_EIP,
        KIND_EIE
    } reg_kind_e;

    typedef logic [XLEN-1:0] xlen_t;

endpackage

`default_nettype wire

// File: verilog/imsic_state_if.sv
// ==========================================================================
// imsic_state_if
// Register state of every interrupt file, seen by the top-interrupt search.
// ==========================================================================
`default_nettype none

interface imsic_state_if import imsic_pkg::*; ();

    logic [NR_FILES-1:0] delivery;
    xlen_t               threshold [NR_FILES];
    xlen_t               eip       [NR_FILES];
    xlen_t               eie       [NR_FILES];

    modport regs (
        output delivery, threshold, eip, eie
    );

    modport sel (
        input delivery, threshold, eip, eie
    );

endinterface

`default_nettype wire

// File: verilog/imsic_top.sv
// ==========================================================================
// imsic_top
// IMSIC interrupt-file block: CSR decoder, register bank and selector.
// ==========================================================================
`default_nettype none

module imsic_top import imsic_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rstn,
    input  wire logic [11:0]        i_csr_addr,
    input  wire logic               i_csr_wdata_vld,
    input  wire logic               i_csr_rd,
    input  wire xlen_t              i_csr_wdata,
    input  wire logic [FILE_W-1:0]  i_file_sel,
    input  wire logic               i_priv_illegal,
    input  wire logic               i_csr_v,
    input  wire logic [VGEIN_W-1:0] i_vgein,
    input  wire logic               i_setipnum_vld,
    input  wire logic [FILE_W-1:0]  i_setipnum_file,
    input  wire logic [ID_W-1:0]    i_setipnum,
    output      xlen_t              o_csr_rdata,
    output      logic               o_csr_rdata_vld,
    output      logic               o_csr_illegal,
    output      logic [2:0]         o_irq,
    output      logic [TOPEI_W-1:0] o_topei_m,
    output      logic [TOPEI_W-1:0] o_topei_s,
    output      logic [TOPEI_W-1:0] o_topei_vs
);

    imsic_csr_if   csr_if_i ();
    imsic_state_if state_if_i ();

    imsic_csr_decode csr_decode_i (
        .clk             (clk),
        .rstn            (rstn),
        .i_csr_addr      (i_csr_addr),
        .i_csr_wdata_vld (i_csr_wdata_vld),
        .i_csr_rd        (i_csr_rd),
        .i_csr_wdata     (i_csr_wdata),
        .i_file_sel      (i_file_sel),
        .i_priv_illegal  (i_priv_illegal),
        .i_csr_v         (i_csr_v),
        .o_csr_illegal   (o_csr_illegal),
        .csr             (csr_if_i.dec)
    );

    imsic_file_regs file_regs_i (
        .clk             (clk),
        .rstn            (rstn),
        .csr             (csr_if_i.regs),
        .i_setipnum_vld  (i_setipnum_vld),
        .i_setipnum_file (i_setipnum_file),
        .i_setipnum      (i_setipnum),
        .o_csr_rdata     (o_csr_rdata),
        .o_csr_rdata_vld (o_csr_rdata_vld),
        .st              (state_if_i.regs)
    );

    imsic_topei topei_i (
        .st         (state_if_i.sel),
        .i_vgein    (i_vgein),
        .o_irq      (o_irq),
        .o_topei_m  (o_topei_m),
        .o_topei_s  (o_topei_s),
        .o_topei_vs (o_topei_vs)
    );

endmodule

`default_nettype wire

// File: verilog/imsic_topei.sv
// ==========================================================================
// imsic_topei
// Per-file search for the lowest enabled pending identity under the
// threshold, and interrupt lines to the machine, supervisor and guest level.
// ==========================================================================
`default_nettype none

module imsic_topei import imsic_pkg::*; (
    imsic_state_if.sel              st,
    input  wire logic [VGEIN_W-1:0] i_vgein,
    output      logic [2:0]         o_irq,
    output      logic [TOPEI_W-1:0] o_topei_m,
    output      logic [TOPEI_W-1:0] o_topei_s,
    output      logic [TOPEI_W-1:0] o_topei_vs
);

    logic [TOPEI_W-1:0]  topei [NR_FILES];
    logic [NR_FILES-1:0] irq;
    logic [FILE_W-1:0]   guest;

    // scan downwards so the lowest identity wins; id 0 is skipped.
    always_comb begin
        for (int f = 0; f < NR_FILES; f++) begin
            topei[f] = '0;
            irq[f]   = 1'b0;
            for (int j = XLEN - 1; j > 0; j--) begin
                if (st.eip[f][j] && st.eie[f][j] &&
                    (st.threshold[f] == '0 || j < st.threshold[f])) begin
                    topei[f] = TOPEI_W'(j);
                    irq[f]   = st.delivery[f];   // only if delivery is on.
                end
            end
        end
    end

    assign guest = FILE_W'(2 + i_vgein);  // guest files start at 2.

    assign o_irq      = {irq[guest], irq[1], irq[0]};
    assign o_topei_m  = topei[0];
    assign o_topei_s  = topei[1];
    assign o_topei_vs = topei[guest];

endmodule

`default_nettype wire
